// File: Makefile
# Verilator build and run of the MMIO register block testbench

VERILATOR ?= verilator
TOP       ?= tb_mmio
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: rtl/action_bridge.sv
/*
 * Bridge from host accesses to the action local bus
 * Data lane selection, response capture and read data placement
 */
`timescale 1ns/1ps

module action_bridge
   import mmio_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  mmio_req_t   req,
   input  logic        act_req,     // Accepted 32-bit action access
   output lcl_req_t    lcl_req,
   input  lcl_rsp_t    lcl_rsp,
   output reg_result_t res
);

   logic pending;                   // Local access outstanding
   logic hi_q;                      // Address bit 2 of the access

   // ==============================
   // Local request
   // ==============================
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         lcl_req <= '0;
         hi_q    <= 1'b0;
         pending <= 1'b0;
      end
      else
      begin
         lcl_req.wr <= act_req && req.wr;        // One-cycle strobes
         lcl_req.rd <= act_req && req.rd;
         if (act_req)
         begin
            lcl_req.addr <= {1'b0, req.addr[ACTION_SEL_BIT-1:0]};   // Space bit cleared
            lcl_req.din  <= req.addr[2] ? req.din[63:32] : req.din[31:0];
            hi_q         <= req.addr[2];
            pending      <= 1'b1;
         end
         else if (lcl_rsp.ack || lcl_rsp.dv)
            pending <= 1'b0;
      end
   end

   // ==============================
   // Action response
   // ==============================
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         res <= '0;
      else
      begin
         res.done <= pending && (lcl_rsp.ack || lcl_rsp.dv);
         res.err  <= pending && (lcl_rsp.ack || lcl_rsp.dv) && !lcl_rsp.rsp;
         if (pending && lcl_rsp.dv)
            res.data <= hi_q ? {lcl_rsp.dout, 32'd0} : {32'd0, lcl_rsp.dout};
         else
            res.data <= 64'd0;   // Writes return no data
      end
   end

   // Action only answers what was sent
   a_rsp_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
      (lcl_rsp.ack || lcl_rsp.dv) |-> pending);

endmodule

// File: rtl/mmio_pkg.sv
/*
 * Shared definitions of the MMIO register block
 * Address map, core register offsets, ID and capability constants
 * Packed structs for host, local bus, sampled inputs and unit results
 */
package mmio_pkg;

   // ==============================
   // Address map
   // ==============================
   localparam int ACTION_SEL_BIT = 31;   // 1 selects the action space
   localparam int BASE_HI        = 21;
   localparam int BASE_LO        = 8;
   localparam int OFFSET_HI      = 7;
   localparam int OFFSET_LO      = 0;

   localparam logic [BASE_HI-BASE_LO:0] BASE_ID    = 14'h000;
   localparam logic [BASE_HI-BASE_LO:0] BASE_DEBUG = 14'h1A0;
   localparam logic [BASE_HI-BASE_LO:0] BASE_FIR   = 14'h1C0;

   // ==============================
   // Register offsets
   // ==============================
   // ID group
   localparam logic [7:0] OFS_IVR          = 8'h00;   // RO
   localparam logic [7:0] OFS_BDR          = 8'h08;   // RO
   localparam logic [7:0] OFS_SCR          = 8'h10;   // WO, command
   localparam logic [7:0] OFS_SSR          = 8'h18;   // RO, status
   localparam logic [7:0] OFS_CAP          = 8'h30;   // RO

   // Debug group
   localparam logic [7:0] OFS_DBG_CLR      = 8'h00;   // WO, self-clearing
   localparam logic [7:0] OFS_TLX_CMD      = 8'h08;   // RO
   localparam logic [7:0] OFS_TLX_RSP      = 8'h10;   // RO
   localparam logic [7:0] OFS_AXI_CMD      = 8'h40;   // RO
   localparam logic [7:0] OFS_AXI_RSP      = 8'h48;   // RO
   localparam logic [7:0] OFS_BUF_CNT      = 8'h50;   // RO
   localparam logic [7:0] OFS_TLX_IDLE_LIM = 8'h60;   // RW
   localparam logic [7:0] OFS_AXI_IDLE_LIM = 8'h68;   // RW

   // FIR group
   localparam logic [7:0] OFS_FIFO_OVFL    = 8'h00;   // RO
   localparam logic [7:0] OFS_TLX_INTRFC   = 8'h08;   // RO

   // ==============================
   // Constants
   // ==============================
   localparam logic [63:0] IMP_VERSION    = 64'h0000_0002_0001_0003;
   localparam logic [63:0] BUILD_DATE     = 64'h0000_0000_0000_0A1B;

   // Capability word fields
   localparam logic [3:0]  CAP_XFER_SIZE  = 4'd6;
   localparam logic [3:0]  CAP_ALIGNMENT  = 4'd6;
   localparam logic [15:0] CAP_SDRAM_SIZE = 16'd4096;   // In MB
   localparam logic [7:0]  CAP_CARD_TYPE  = 8'h31;

   localparam int SOFT_RESET_CYCLES = 16;

   // ==============================
   // Types
   // ==============================
   typedef struct packed {
      logic        wr;
      logic        rd;
      logic        dw;     // 1 for a 64-bit access
      logic [31:0] addr;
      logic [63:0] din;
   } mmio_req_t;

   typedef struct packed {
      logic [63:0] tlx_cmd;
      logic [63:0] tlx_rsp;
      logic [63:0] axi_cmd;
      logic [63:0] axi_rsp;
      logic [63:0] buf_cnt;
   } debug_cnt_t;

   typedef struct packed {
      logic [63:0] fifo_overflow;
      logic [63:0] tlx_interface;
   } fir_t;

   typedef struct packed {
      logic [63:0] tlx;
      logic [63:0] axi;
   } idle_lim_t;

   typedef struct packed {
      logic        wr;
      logic        rd;
      logic [31:0] addr;
      logic [31:0] din;
   } lcl_req_t;

   typedef struct packed {
      logic        ack;    // Ends a write
      logic        dv;     // Ends a read
      logic        rsp;    // 1 is good
      logic [31:0] dout;
   } lcl_rsp_t;

   typedef struct packed {
      logic        done;
      logic        err;
      logic [63:0] data;
   } reg_result_t;

endpackage

// File: rtl/mmio_resp_merge.sv
/*
 * Width check, request steering and host response merge
 */
`timescale 1ns/1ps

module mmio_resp_merge
   import mmio_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  mmio_req_t   req,
   output logic        core_req,
   output logic        act_req,
   input  reg_result_t core_res,
   input  reg_result_t act_res,
   output logic [63:0] dout,
   output logic        done,
   output logic        failed
);

   logic access;
   logic act_space;
   logic width_err;

   assign access    = req.wr || req.rd;
   assign act_space = req.addr[ACTION_SEL_BIT];
   // Action wants 32 bits, core wants 64 bits
   assign width_err = access && (act_space == req.dw);
   assign core_req  = access && !act_space && req.dw;
   assign act_req   = access && act_space && !req.dw;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         done   <= 1'b0;
         failed <= 1'b0;
         dout   <= 64'd0;
      end
      else
      begin
         done   <= (core_res.done && !core_res.err) || (act_res.done && !act_res.err);
         failed <= width_err || (core_res.done && core_res.err)
                             || (act_res.done && act_res.err);
         if (core_res.done)
            dout <= core_res.data;
         else if (act_res.done)
            dout <= act_res.data;
      end
   end

   a_one_outcome: assert property (@(posedge clk) disable iff (!rst_n)
      !(done && failed));

endmodule

// File: rtl/mmio_top.sv
/*
 * Top level of the MMIO register block
 * Width check and response merge, core registers, action bridge
 * and the two soft-reset pulse generators
 */
`timescale 1ns/1ps

module mmio_top
   import mmio_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,

   // Host side
   input  mmio_req_t   req,
   output logic [63:0] dout,
   output logic        done,
   output logic        failed,

   // Shell debug and FIR
   input  debug_cnt_t  dbg,
   input  fir_t        fir,
   output logic        debug_cnt_clear,
   output idle_lim_t   idle_lim,

   // Soft resets
   output logic        soft_reset_shell,
   output logic        soft_reset_action,

   // Action local bus
   output lcl_req_t    lcl_req,
   input  lcl_rsp_t    lcl_rsp
);

   logic        core_req;            // Accepted core access
   logic        act_req;             // Accepted action access
   reg_result_t core_res;
   reg_result_t act_res;
   logic        soft_reset_req;      // Command bit 0 written

   mmio_resp_merge u_merge (
      .clk      (clk),
      .rst_n    (rst_n),
      .req      (req),
      .core_req (core_req),
      .act_req  (act_req),
      .core_res (core_res),
      .act_res  (act_res),
      .dout     (dout),
      .done     (done),
      .failed   (failed)
   );

   snap_core_regs u_core (
      .clk             (clk),
      .rst_n           (rst_n),
      .req             (req),
      .core_req        (core_req),
      .dbg             (dbg),
      .fir             (fir),
      .res             (core_res),
      .debug_cnt_clear (debug_cnt_clear),
      .idle_lim        (idle_lim),
      .soft_reset_req  (soft_reset_req)
   );

   action_bridge u_action (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (req),
      .act_req (act_req),
      .lcl_req (lcl_req),
      .lcl_rsp (lcl_rsp),
      .res     (act_res)
   );

   // Same request strobe starts both pulses
   soft_reset_gen u_rst_shell (
      .clk        (clk),
      .rst_n      (rst_n),
      .start      (soft_reset_req),
      .soft_reset (soft_reset_shell)
   );

   soft_reset_gen u_rst_action (
      .clk        (clk),
      .rst_n      (rst_n),
      .start      (soft_reset_req),
      .soft_reset (soft_reset_action)
   );

endmodule

// File: rtl/snap_core_regs.sv
/*
 * Shell core register file
 * ID, debug and FIR groups with write and read decode,
 * sampled counters, status word and decode errors
 */
`timescale 1ns/1ps

module snap_core_regs
   import mmio_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  mmio_req_t   req,
   input  logic        core_req,          // Width already checked
   input  debug_cnt_t  dbg,
   input  fir_t        fir,
   output reg_result_t res,
   output logic        debug_cnt_clear,
   output idle_lim_t   idle_lim,
   output logic        soft_reset_req
);

   logic [BASE_HI-BASE_LO:0]     base;
   logic [OFFSET_HI-OFFSET_LO:0] ofs;

   debug_cnt_t  dbg_q;                    // Sampled counters
   fir_t        fir_q;                    // Sampled FIR words
   logic [3:0]  status_q;                 // {fatal, axi_busy, tlx_busy, idle}

   logic [63:0] rd_data;
   logic        rd_ok;
   logic        wr_scr, wr_clr, wr_tlx_lim, wr_axi_lim;
   logic        wr_ok;
   logic        dec_err;

   assign base = req.addr[BASE_HI:BASE_LO];
   assign ofs  = req.addr[OFFSET_HI:OFFSET_LO];

   // ==============================
   // Sampled inputs and status
   // ==============================
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         dbg_q    <= '0;
         fir_q    <= '0;
         status_q <= '0;
      end
      else
      begin
         dbg_q       <= dbg;
         fir_q       <= fir;
         // Status lags the samples by one more cycle
         status_q[0] <= (dbg_q.buf_cnt == 64'd0);              // Idle, buffers empty
         status_q[1] <= (dbg_q.tlx_cmd != dbg_q.tlx_rsp);     // TLX busy
         status_q[2] <= (dbg_q.axi_cmd != dbg_q.axi_rsp);     // AXI busy
         status_q[3] <= |{fir_q.fifo_overflow, fir_q.tlx_interface};   // Fatal
      end
   end

   // ==============================
   // Address decode
   // ==============================
   always_comb
   begin
      rd_data    = '0;
      rd_ok      = 1'b0;
      wr_scr     = 1'b0;
      wr_clr     = 1'b0;
      wr_tlx_lim = 1'b0;
      wr_axi_lim = 1'b0;
      case (base)
         BASE_ID:
            case (ofs)
               OFS_IVR: begin rd_ok = 1'b1; rd_data = IMP_VERSION; end
               OFS_BDR: begin rd_ok = 1'b1; rd_data = BUILD_DATE; end
               OFS_SCR: wr_scr = 1'b1;                    // Write only
               OFS_SSR: begin rd_ok = 1'b1; rd_data = {60'd0, status_q}; end
               OFS_CAP:
               begin
                  rd_ok   = 1'b1;
                  rd_data = {24'd0, CAP_XFER_SIZE, CAP_ALIGNMENT, CAP_SDRAM_SIZE,
                             8'd0, CAP_CARD_TYPE};
               end
               default: ;
            endcase
         BASE_DEBUG:
            case (ofs)
               OFS_DBG_CLR: wr_clr = 1'b1;                // Write only
               OFS_TLX_CMD: begin rd_ok = 1'b1; rd_data = dbg_q.tlx_cmd; end
               OFS_TLX_RSP: begin rd_ok = 1'b1; rd_data = dbg_q.tlx_rsp; end
               OFS_AXI_CMD: begin rd_ok = 1'b1; rd_data = dbg_q.axi_cmd; end
               OFS_AXI_RSP: begin rd_ok = 1'b1; rd_data = dbg_q.axi_rsp; end
               OFS_BUF_CNT: begin rd_ok = 1'b1; rd_data = dbg_q.buf_cnt; end
               OFS_TLX_IDLE_LIM:
               begin
                  rd_ok      = 1'b1;
                  rd_data    = idle_lim.tlx;
                  wr_tlx_lim = 1'b1;
               end
               OFS_AXI_IDLE_LIM:
               begin
                  rd_ok      = 1'b1;
                  rd_data    = idle_lim.axi;
                  wr_axi_lim = 1'b1;
               end
               default: ;
            endcase
         BASE_FIR:
            case (ofs)
               OFS_FIFO_OVFL:  begin rd_ok = 1'b1; rd_data = fir_q.fifo_overflow; end
               OFS_TLX_INTRFC: begin rd_ok = 1'b1; rd_data = fir_q.tlx_interface; end
               default: ;
            endcase
         default: ;                               // Unknown base, nothing hits
      endcase
   end

   assign wr_ok   = wr_scr | wr_clr | wr_tlx_lim | wr_axi_lim;
   // Read-only write, write-only read and unknown addresses all land here
   assign dec_err = req.wr ? !wr_ok : !rd_ok;

   // ==============================
   // Register writes and result
   // ==============================
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         res             <= '0;
         idle_lim        <= '0;
         debug_cnt_clear <= 1'b0;
         soft_reset_req  <= 1'b0;
      end
      else
      begin
         res.done        <= core_req;
         res.err         <= core_req && dec_err;
         res.data        <= (core_req && req.rd) ? rd_data : 64'd0;
         // Self-clearing strobes
         debug_cnt_clear <= core_req && req.wr && wr_clr && req.din[0];
         soft_reset_req  <= core_req && req.wr && wr_scr && req.din[0];
         if (core_req && req.wr && wr_tlx_lim)
            idle_lim.tlx <= req.din;
         if (core_req && req.wr && wr_axi_lim)
            idle_lim.axi <= req.din;
      end
   end

   // Host waits for done, so no new access overlaps a returning result
   a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
      core_req |-> !res.done);

endmodule

// File: rtl/soft_reset_gen.sv
/*
 * Fixed-length soft-reset pulse from a command strobe
 */
`timescale 1ns/1ps

module soft_reset_gen
   import mmio_pkg::*;
#(
   parameter int pulse_len = SOFT_RESET_CYCLES
)
(
   input  logic clk,
   input  logic rst_n,
   input  logic start,
   output logic soft_reset
);

   logic [$clog2(pulse_len)-1:0] cnt;   // Cycles spent high

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         soft_reset <= 1'b0;
         cnt        <= '0;
      end
      else if (soft_reset)
      begin
         cnt <= cnt + 1'b1;
         if (cnt == $bits(cnt)'(pulse_len - 1))
         begin
            soft_reset <= 1'b0;          // Pulse_len cycles done
            cnt        <= '0;
         end
      end
      else if (start)
         soft_reset <= 1'b1;             // Start while active is ignored
   end

endmodule

// File: sim/tb_mmio.sv
/*
 * Testbench of the MMIO register block
 * Clock and reset, action model, reference function,
 * compare tasks, directed tests and watchdog
 */
`timescale 1ns/1ps

module tb_mmio
   import mmio_pkg::*;
();

   localparam int CLK_PERIOD   = 100;
   localparam int DRIVE_DLY    = 1;      // Inputs change this long after the rising edge
   localparam int NUM_ACCESSES = 29;
   localparam int MAX_WAIT     = 40;     // Cycles before an access counts as lost

   logic        clk;
   logic        rst_n;
   mmio_req_t   req;
   logic [63:0] dout;
   logic        done;
   logic        failed;
   debug_cnt_t  dbg;
   fir_t        fir;
   logic        debug_cnt_clear;
   idle_lim_t   idle_lim;
   logic        soft_reset_shell;
   logic        soft_reset_action;
   lcl_req_t    lcl_req;
   lcl_rsp_t    lcl_rsp;

   logic [31:0] rng = 32'h1d9f8214;
   int          errors;
   int          checks;
   int          lcl_cnt;                // Local strobes seen by the action model
   lcl_req_t    last_lcl;               // Last local request captured
   idle_lim_t   lim_model;              // Expected idle limits
   reg_result_t exp_q[$];               // Expected results, oldest first
   logic        rd_q[$];                // Matching read flags
   time         last_strobe_t;          // Falling edge that first shows the strobe
   time         rise_t[3];              // 0 clear, 1 shell, 2 action
   int          plen[3];
   logic [2:0]  pulse_prev;

   mmio_top DUT (
      .clk               (clk),
      .rst_n             (rst_n),
      .req               (req),
      .dout              (dout),
      .done              (done),
      .failed            (failed),
      .dbg               (dbg),
      .fir               (fir),
      .debug_cnt_clear   (debug_cnt_clear),
      .idle_lim          (idle_lim),
      .soft_reset_shell  (soft_reset_shell),
      .soft_reset_action (soft_reset_action),
      .lcl_req           (lcl_req),
      .lcl_rsp           (lcl_rsp)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   // ==============================
   // Helpers and reference
   // ==============================
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] s;
      s = x;
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   task automatic rand64(output logic [63:0] v);
      rng      = xorshift32(rng);
      v[63:32] = rng;
      rng      = xorshift32(rng);
      v[31:0]  = rng;
   endtask

   function automatic logic [31:0] core_addr(input logic [13:0] b, input logic [7:0] o);
      return {10'd0, b, o};                          // Bit 31 clear, core space
   endfunction

   function automatic mmio_req_t make_req(input logic wr, input logic dw,
                                          input logic [31:0] addr, input logic [63:0] din);
      mmio_req_t r;
      r.wr   = wr;
      r.rd   = !wr;
      r.dw   = dw;
      r.addr = addr;
      r.din  = din;
      return r;
   endfunction

   // Expected outcome of one access, from the register map and the model rules
   function automatic reg_result_t ref_access(input mmio_req_t r, input debug_cnt_t d,
                                              input fir_t f, input idle_lim_t lim);
      reg_result_t e;
      logic [31:0] la;
      logic [31:0] ld;
      logic [21:0] key;
      logic [63:0] val;
      logic [63:0] cap;
      logic [3:0]  status;
      logic        hit;
      logic        wo;
      logic        rw;
      e      = '0;
      e.done = 1'b1;
      if (r.addr[ACTION_SEL_BIT] == r.dw)            // Width does not fit the space
      begin
         e.err = 1'b1;
         return e;
      end
      if (r.addr[ACTION_SEL_BIT])
      begin
         la    = {1'b0, r.addr[30:0]};
         ld    = la ^ 32'hA5A5_0000;                  // Model read data
         e.err = la[12];                              // Model answers bad on bit 12
         if (r.rd)
            e.data = r.addr[2] ? {ld, 32'd0} : {32'd0, ld};
         return e;
      end
      status[0] = (d.buf_cnt == 64'd0);
      status[1] = (d.tlx_cmd != d.tlx_rsp);
      status[2] = (d.axi_cmd != d.axi_rsp);
      status[3] = |f;
      cap        = '0;
      cap[7:0]   = CAP_CARD_TYPE;
      cap[31:16] = CAP_SDRAM_SIZE;
      cap[35:32] = CAP_ALIGNMENT;
      cap[39:36] = CAP_XFER_SIZE;
      key = r.addr[BASE_HI:OFFSET_LO];
      hit = 1'b1;
      wo  = 1'b0;
      val = '0;
      case (key)
         {BASE_ID, OFS_IVR}:               val = IMP_VERSION;
         {BASE_ID, OFS_BDR}:               val = BUILD_DATE;
         {BASE_ID, OFS_SCR}:               wo  = 1'b1;
         {BASE_ID, OFS_SSR}:               val = {60'd0, status};
         {BASE_ID, OFS_CAP}:               val = cap;
         {BASE_DEBUG, OFS_DBG_CLR}:        wo  = 1'b1;
         {BASE_DEBUG, OFS_TLX_CMD}:        val = d.tlx_cmd;
         {BASE_DEBUG, OFS_TLX_RSP}:        val = d.tlx_rsp;
         {BASE_DEBUG, OFS_AXI_CMD}:        val = d.axi_cmd;
         {BASE_DEBUG, OFS_AXI_RSP}:        val = d.axi_rsp;
         {BASE_DEBUG, OFS_BUF_CNT}:        val = d.buf_cnt;
         {BASE_DEBUG, OFS_TLX_IDLE_LIM}:   val = lim.tlx;
         {BASE_DEBUG, OFS_AXI_IDLE_LIM}:   val = lim.axi;
         {BASE_FIR, OFS_FIFO_OVFL}:        val = f.fifo_overflow;
         {BASE_FIR, OFS_TLX_INTRFC}:       val = f.tlx_interface;
         default:                          hit = 1'b0;
      endcase
      // Only the two limits take writes besides the write-only pair
      rw    = (key == {BASE_DEBUG, OFS_TLX_IDLE_LIM}) || (key == {BASE_DEBUG, OFS_AXI_IDLE_LIM});
      e.err = !hit || (r.wr && !wo && !rw) || (r.rd && wo);
      if (r.rd && !e.err)
         e.data = val;
      return e;
   endfunction

   // ==============================
   // Reporting and compare tasks
   // ==============================
   task automatic report_fail(input string msg);
      errors = errors + 1;
      $display("Fail at %0t: %s", $time, msg);
   endtask

   task automatic note_problem(input string msg);
      errors = errors + 1;
      $display("%s", msg);
   endtask

   task automatic check_result(input reg_result_t e, input logic is_rd);
      checks = checks + 1;
      if (done !== !e.err || failed !== e.err)
         report_fail($sformatf("expected %s, got done %b failed %b",
                               e.err ? "failed" : "done", done, failed));
      else if (is_rd && !e.err && dout !== e.data)
         report_fail($sformatf("read data %h, expected %h", dout, e.data));
   endtask

   task automatic check_lcl(input lcl_req_t e);
      checks = checks + 1;
      if (last_lcl !== e)
         report_fail($sformatf("local request %h, expected %h", last_lcl, e));
   endtask

   task automatic check_lim(input idle_lim_t e);
      checks = checks + 1;
      if (idle_lim !== e)
         report_fail($sformatf("idle_lim %h, expected %h", idle_lim, e));
   endtask

   task automatic check_latency(input int got, input int exp);
      checks = checks + 1;
      if (got != exp)
         report_fail($sformatf("response after %0d cycles, expected %0d", got, exp));
   endtask

   task automatic check_pulse(input string name, input int idx, input int exp_start,
                              input int exp_len);
      int got_start;
      got_start = int'((rise_t[idx] - last_strobe_t) / CLK_PERIOD);
      checks    = checks + 1;
      if (got_start != exp_start || plen[idx] != exp_len)
         report_fail($sformatf("%s rose after %0d and lasted %0d, expected %0d and %0d",
                               name, got_start, plen[idx], exp_start, exp_len));
   endtask

   task automatic end_test(input string name, input int err0);
      if (errors == err0)
         $display("Test %-18s ok", name);
      else
         $display("Test %-18s %0d errors", name, errors - err0);
   endtask

   // ==============================
   // Access tasks
   // ==============================
   task automatic run_access(input mmio_req_t r, output int latency);
      int   n;
      int   cnt0;
      logic fwd;
      exp_q.push_back(ref_access(r, dbg, fir, lim_model));
      rd_q.push_back(r.rd);
      cnt0 = lcl_cnt;
      fwd  = r.addr[ACTION_SEL_BIT] && !r.dw;       // Only this kind leaves the block
      req  = r;
      last_strobe_t = $time + CLK_PERIOD/2 - DRIVE_DLY;
      @(posedge clk);
      #(DRIVE_DLY);
      req = '0;                                     // Strobe lasts one cycle
      n   = 1;
      do
      begin
         @(negedge clk);
         n = n + 1;
      end
      while (!(done || failed) && n < MAX_WAIT);
      latency = n - 1;
      if (!(done || failed))
         note_problem($sformatf("No done or failed for the access at address %h", r.addr));
      @(posedge clk);
      #(DRIVE_DLY);
      // Model has seen every strobe up to the response by now
      if ((lcl_cnt - cnt0) != (fwd ? 1 : 0))
         report_fail($sformatf("%0d local strobes for address %h", lcl_cnt - cnt0, r.addr));
   endtask

   task automatic core_read(input logic [13:0] b, input logic [7:0] o);
      int lat;
      run_access(make_req(1'b0, 1'b1, core_addr(b, o), 64'd0), lat);
   endtask

   task automatic core_write(input logic [13:0] b, input logic [7:0] o, input logic [63:0] v);
      int lat;
      run_access(make_req(1'b1, 1'b1, core_addr(b, o), v), lat);
   endtask

   task automatic act_access(input logic wr, input logic [31:0] addr, input logic [63:0] v);
      int       lat;
      lcl_req_t e;
      e.wr   = wr;
      e.rd   = !wr;
      e.addr = {1'b0, addr[30:0]};
      e.din  = addr[2] ? v[63:32] : v[31:0];        // Lane picked by bit 2
      run_access(make_req(wr, 1'b0, addr, v), lat);
      check_lcl(e);
   endtask

   // ==============================
   // Monitors and action model
   // ==============================
   always @(negedge clk)
   begin
      reg_result_t e;
      logic        is_rd;
      if (rst_n && (done || failed))
      begin
         if (exp_q.size() == 0)
            note_problem("The DUT answered with no access outstanding");
         else
         begin
            e     = exp_q.pop_front();
            is_rd = rd_q.pop_front();
            check_result(e, is_rd);
         end
      end
   end

   // Rise time and length of clear and soft-reset pulses
   always @(negedge clk)
   begin
      logic [2:0] now;
      now = {soft_reset_action, soft_reset_shell, debug_cnt_clear};
      for (int i = 0; i < 3; i++)
      begin
         if (now[i] && !pulse_prev[i])
         begin
            rise_t[i] = $time;
            plen[i]   = 1;
         end
         else if (now[i])
            plen[i] = plen[i] + 1;
      end
      pulse_prev = now;
   end

   // Action answers each strobe after 1 to 4 cycles
   initial
   begin
      int dly;
      lcl_cnt = 0;
      forever
      begin
         @(negedge clk);
         if (rst_n && (lcl_req.wr || lcl_req.rd))
         begin
            last_lcl = lcl_req;
            lcl_cnt  = lcl_cnt + 1;
            rng      = xorshift32(rng);
            dly      = 1 + int'(rng[1:0]);
            repeat (dly) @(posedge clk);
            #(DRIVE_DLY);
            lcl_rsp.ack  = last_lcl.wr;
            lcl_rsp.dv   = last_lcl.rd;
            lcl_rsp.rsp  = !last_lcl.addr[12];        // Bad response on bit 12
            lcl_rsp.dout = last_lcl.rd ? (last_lcl.addr ^ 32'hA5A5_0000) : 32'd0;
            @(posedge clk);
            #(DRIVE_DLY);
            lcl_rsp = '0;
         end
      end
   end

   initial
   begin
      repeat (NUM_ACCESSES * 20 + 200) @(posedge clk);
      $display("Timeout, the tests did not end within %0d cycles", NUM_ACCESSES * 20 + 200);
      $display("** FAIL **");
      $finish;
   end

   // ==============================
   // Tests
   // ==============================
   initial
   begin
      logic [63:0] v;
      int          lat;
      int          err0;
      rst_n      = 1'b0;
      req        = '0;
      dbg        = '0;
      fir        = '0;
      lcl_rsp    = '0;
      errors     = 0;
      checks     = 0;
      lim_model  = '0;
      last_lcl   = '0;
      pulse_prev = '0;
      rise_t     = '{default: 0};
      plen       = '{default: 0};
      repeat (3) @(posedge clk);
      #(DRIVE_DLY);
      rst_n = 1'b1;
      @(posedge clk);
      #(DRIVE_DLY);

      // ID constants, fixed two-cycle latency
      err0 = errors;
      run_access(make_req(1'b0, 1'b1, core_addr(BASE_ID, OFS_IVR), 64'd0), lat);
      check_latency(lat, 2);
      run_access(make_req(1'b0, 1'b1, core_addr(BASE_ID, OFS_BDR), 64'd0), lat);
      check_latency(lat, 2);
      run_access(make_req(1'b0, 1'b1, core_addr(BASE_ID, OFS_CAP), 64'd0), lat);
      check_latency(lat, 2);
      end_test("id_constants", err0);

      err0 = errors;
      rand64(v);
      lim_model.tlx = v;
      core_write(BASE_DEBUG, OFS_TLX_IDLE_LIM, v);
      rand64(v);
      lim_model.axi = v;
      core_write(BASE_DEBUG, OFS_AXI_IDLE_LIM, v);
      core_read(BASE_DEBUG, OFS_TLX_IDLE_LIM);
      core_read(BASE_DEBUG, OFS_AXI_IDLE_LIM);
      check_lim(lim_model);
      end_test("idle_limits", err0);

      // Sampled counters, FIR words and status
      err0 = errors;
      for (int i = 0; i < 5; i++)
      begin
         rand64(v);
         dbg[i*64 +: 64] = v;
      end
      for (int i = 0; i < 2; i++)
      begin
         rand64(v);
         fir[i*64 +: 64] = v;
      end
      repeat (4) @(posedge clk);
      #(DRIVE_DLY);
      core_read(BASE_DEBUG, OFS_TLX_CMD);
      core_read(BASE_DEBUG, OFS_TLX_RSP);
      core_read(BASE_DEBUG, OFS_AXI_CMD);
      core_read(BASE_DEBUG, OFS_AXI_RSP);
      core_read(BASE_DEBUG, OFS_BUF_CNT);
      core_read(BASE_FIR, OFS_FIFO_OVFL);
      core_read(BASE_FIR, OFS_TLX_INTRFC);
      core_read(BASE_ID, OFS_SSR);
      dbg.buf_cnt = 64'd0;                          // Idle, TLX and AXI quiet, no FIR
      dbg.tlx_rsp = dbg.tlx_cmd;
      dbg.axi_rsp = dbg.axi_cmd;
      fir         = '0;
      repeat (4) @(posedge clk);
      #(DRIVE_DLY);
      core_read(BASE_ID, OFS_SSR);
      end_test("sampled_inputs", err0);

      err0 = errors;
      run_access(make_req(1'b0, 1'b0, core_addr(BASE_ID, OFS_IVR), 64'd0), lat);
      run_access(make_req(1'b0, 1'b1, 32'h8000_0010, 64'd0), lat);
      core_read(BASE_ID, 8'h20);                    // Hole in the ID group
      core_write(BASE_ID, OFS_IVR, 64'h1);
      core_read(BASE_ID, OFS_SCR);
      end_test("errors", err0);

      // Action bridge lanes and responses
      err0 = errors;
      rand64(v);
      act_access(1'b1, 32'h8000_0100, v);
      rand64(v);
      act_access(1'b1, 32'h8000_0104, v);
      act_access(1'b0, 32'h8000_0208, 64'd0);
      act_access(1'b0, 32'h8000_020C, 64'd0);
      act_access(1'b1, 32'h8000_1000, v);
      act_access(1'b0, 32'h8000_1004, 64'd0);
      end_test("action_bridge", err0);

      err0 = errors;
      core_write(BASE_ID, OFS_SCR, 64'h1);
      repeat (20) @(posedge clk);
      #(DRIVE_DLY);
      check_pulse("soft_reset_shell", 1, 2, SOFT_RESET_CYCLES);
      check_pulse("soft_reset_action", 2, 2, SOFT_RESET_CYCLES);
      core_write(BASE_DEBUG, OFS_DBG_CLR, 64'h1);
      repeat (3) @(posedge clk);
      #(DRIVE_DLY);
      check_pulse("debug_cnt_clear", 0, 1, 1);
      end_test("pulses", err0);

      repeat (2) @(posedge clk);
      if (exp_q.size() != 0)
         note_problem("Accesses were left without a response");
      $display("Checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

// File: sources.f
rtl/mmio_pkg.sv
rtl/soft_reset_gen.sv
rtl/action_bridge.sv
rtl/snap_core_regs.sv
rtl/mmio_resp_merge.sv
rtl/mmio_top.sv
sim/tb_mmio.sv
